// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       ?= tb_md5_search
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+testbench
hw/md5_search_pkg.sv
hw/ascii_counter.sv
hw/message_concat.sv
hw/md5_block.sv
hw/search_control.sv
hw/md5_search_top.sv
testbench/tb_md5_search.sv

// ==== hw/ascii_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module ascii_counter #(
    parameter int MAX_SUFFIX_LENGTH = 8 // digits
) (
    input wire clk,
    input wire reset,
    input wire suffix_ready,
    output logic suffix_valid,
    output logic [$clog2(1+MAX_SUFFIX_LENGTH)-1:0] suffix_digits,
    output logic [8*MAX_SUFFIX_LENGTH-1:0] suffix_number // lsd in byte 0
);

logic [8*MAX_SUFFIX_LENGTH-1:0] next_number;
logic [$clog2(1+MAX_SUFFIX_LENGTH)-1:0] next_digits;
logic carry;

// ripple carry over the ascii digits
always_comb begin
    next_number = suffix_number;
    next_digits = suffix_digits;
    carry = 1'b1;
    for (int i = 0; i < MAX_SUFFIX_LENGTH; i++) begin
        if (carry) begin
            if (i >= suffix_digits) begin // carry out of top digit
                next_number[8*i+:8] = "1";
                next_digits = suffix_digits + 1'b1;
                carry = 1'b0;
            end else if (suffix_number[8*i+:8] == "9") begin
                next_number[8*i+:8] = "0";
            end else begin
                next_number[8*i+:8] = suffix_number[8*i+:8] + 8'd1;
                carry = 1'b0;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (reset) begin
        suffix_valid <= 1'b0;
        suffix_digits <= 1;
        suffix_number <= {{(8*MAX_SUFFIX_LENGTH-8){1'b0}}, "1"};
    end else begin
        suffix_valid <= 1'b1; // a next number always exists
        if (suffix_valid && suffix_ready) begin
            suffix_digits <= next_digits;
            suffix_number <= next_number;
        end
    end
end

endmodule

`default_nettype wire

// ==== hw/md5_block.sv ====
`timescale 1ns/100ps
`default_nettype none

module md5_block #(
    parameter int MAX_MSG_LENGTH = 32 // bytes
) (
    input wire clk,
    input wire reset,
    input wire msg_valid,
    output logic msg_ready,
    input wire [$clog2(MAX_MSG_LENGTH)-1:0] msg_length,
    input wire [8*MAX_MSG_LENGTH-1:0] msg_data,
    output logic digest_valid,
    output md5_search_pkg::digest_t digest
);

import md5_search_pkg::*;

typedef enum logic [1:0] {st_idle, st_load, st_round} core_state_t;

core_state_t state;
logic [8*MAX_MSG_LENGTH-1:0] msg_q;
logic [$clog2(MAX_MSG_LENGTH)-1:0] length_q;
block_t block;
word_t a, b, c, d;
round_t round;
word_t f, sum, rotated, b_next;
logic [3:0] g;

function automatic word_t bswap(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// message bytes into little-endian words then zero fill and bit count
always_comb begin
    block = '0;
    for (int j = 0; j < MAX_MSG_LENGTH; j++) begin
        block[8*j+:8] = msg_q[8*(MAX_MSG_LENGTH-1-j)+:8];
    end
    block[32*14+:32] = word_t'(length_q) << 3; // M[14]
end

always_comb begin
    case (round[5:4])
        2'd0: begin
            f = (b & c) | (~b & d);
            g = round[3:0];
        end
        2'd1: begin
            f = (d & b) | (~d & c);
            g = 4'(5 * round + 1);
        end
        2'd2: begin
            f = b ^ c ^ d;
            g = 4'(3 * round + 5);
        end
        default: begin
            f = c ^ (b | ~d);
            g = 4'(7 * round);
        end
    endcase
    sum = a + f + md5_k[round] + block[32*g+:32];
    rotated = (sum << md5_s[round]) | (sum >> (32 - md5_s[round]));
    b_next = b + rotated;
end

assign msg_ready = (state == st_idle);

always_ff @(posedge clk) begin
    if (reset) begin
        state <= st_idle;
        digest_valid <= 1'b0;
    end else begin
        digest_valid <= 1'b0;
        case (state)
            st_idle: begin
                if (msg_valid)
                    state <= st_load;
            end
            st_load: state <= st_round;
            st_round: begin
                if (round == 6'd63) begin
                    state <= st_idle;
                    digest_valid <= 1'b1;
                end
            end
            default: state <= st_idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == st_idle && msg_valid) begin
        msg_q <= msg_data;
        length_q <= msg_length;
    end
    if (state == st_load) begin
        a <= md5_init[0];
        b <= md5_init[1];
        c <= md5_init[2];
        d <= md5_init[3];
        round <= '0;
    end else if (state == st_round) begin
        a <= d;
        b <= b_next;
        c <= b;
        d <= c;
        round <= round + 1'b1;
        if (round == 6'd63) begin // add initial state on the last round
            digest <= {bswap(md5_init[0] + d), bswap(md5_init[1] + b_next),
                       bswap(md5_init[2] + b), bswap(md5_init[3] + c)};
        end
    end
end

endmodule

`default_nettype wire

// ==== hw/md5_search_pkg.sv ====
`default_nettype none

package md5_search_pkg;

    typedef logic [31:0] word_t;
    typedef logic [127:0] digest_t;   // A B C D in md5 output byte order
    typedef logic [511:0] block_t;
    typedef logic [31:0] answer_t;
    typedef logic [5:0] round_t;

    // sine table
    localparam word_t md5_k [64] = '{
        32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
        32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
        32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
        32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
        32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
        32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
        32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
        32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
        32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
        32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
        32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
        32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
        32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
        32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
        32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
        32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
    };

    // per-round left rotate amounts
    localparam logic [4:0] md5_s [64] = '{
        5'd7, 5'd12, 5'd17, 5'd22, 5'd7, 5'd12, 5'd17, 5'd22,
        5'd7, 5'd12, 5'd17, 5'd22, 5'd7, 5'd12, 5'd17, 5'd22,
        5'd5, 5'd9, 5'd14, 5'd20, 5'd5, 5'd9, 5'd14, 5'd20,
        5'd5, 5'd9, 5'd14, 5'd20, 5'd5, 5'd9, 5'd14, 5'd20,
        5'd4, 5'd11, 5'd16, 5'd23, 5'd4, 5'd11, 5'd16, 5'd23,
        5'd4, 5'd11, 5'd16, 5'd23, 5'd4, 5'd11, 5'd16, 5'd23,
        5'd6, 5'd10, 5'd15, 5'd21, 5'd6, 5'd10, 5'd15, 5'd21,
        5'd6, 5'd10, 5'd15, 5'd21, 5'd6, 5'd10, 5'd15, 5'd21
    };

    localparam word_t md5_init [4] = '{
        32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476
    };

endpackage

`default_nettype wire

// ==== hw/md5_search_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module md5_search_top #(
    parameter int MAX_KEY_LENGTH = 16,
    parameter int MAX_SUFFIX_LENGTH = 8,
    parameter int MAX_MSG_LENGTH = 32,
    parameter int ZERO_NIBBLES = 5
) (
    input wire clk,
    input wire reset,
    input wire start_req,
    input wire [3:0] key_chars,
    input wire [8*MAX_KEY_LENGTH-1:0] key_value,
    output logic done_ack,
    output md5_search_pkg::answer_t answer,
    output md5_search_pkg::digest_t digest
);

import md5_search_pkg::*;

logic pipe_reset;
logic secret_key_valid;
logic suffix_valid;
logic suffix_ready;
logic [$clog2(1+MAX_SUFFIX_LENGTH)-1:0] suffix_digits;
logic [8*MAX_SUFFIX_LENGTH-1:0] suffix_number;
logic msg_valid;
logic msg_ready;
logic [$clog2(MAX_MSG_LENGTH)-1:0] msg_length;
logic [8*MAX_MSG_LENGTH-1:0] msg_data;
logic digest_valid;
digest_t core_digest;

search_control #(
    .ZERO_NIBBLES(ZERO_NIBBLES)
) control0 (
    .clk(clk),
    .reset(reset),
    .start_req(start_req),
    .done_ack(done_ack),
    .pipe_reset(pipe_reset),
    .searching(secret_key_valid),
    .digest_valid(digest_valid),
    .digest_in(core_digest),
    .answer(answer),
    .digest(digest)
);

ascii_counter #(
    .MAX_SUFFIX_LENGTH(MAX_SUFFIX_LENGTH)
) counter0 (
    .clk(clk),
    .reset(pipe_reset),
    .suffix_ready(suffix_ready),
    .suffix_valid(suffix_valid),
    .suffix_digits(suffix_digits),
    .suffix_number(suffix_number)
);

message_concat #(
    .MAX_KEY_LENGTH(MAX_KEY_LENGTH),
    .MAX_SUFFIX_LENGTH(MAX_SUFFIX_LENGTH),
    .MAX_MSG_LENGTH(MAX_MSG_LENGTH)
) concat0 (
    .clk(clk),
    .reset(pipe_reset),
    .secret_key_valid(secret_key_valid),
    .secret_key_chars(key_chars),
    .secret_key_value(key_value),
    .suffix_ready(suffix_ready),
    .suffix_valid(suffix_valid),
    .suffix_digits(suffix_digits),
    .suffix_number(suffix_number),
    .msg_ready(msg_ready),
    .msg_valid(msg_valid),
    .msg_length(msg_length),
    .msg_data(msg_data)
);

md5_block #(
    .MAX_MSG_LENGTH(MAX_MSG_LENGTH)
) core0 (
    .clk(clk),
    .reset(pipe_reset),
    .msg_valid(msg_valid),
    .msg_ready(msg_ready),
    .msg_length(msg_length),
    .msg_data(msg_data),
    .digest_valid(digest_valid),
    .digest(core_digest)
);

endmodule

`default_nettype wire

// ==== hw/message_concat.sv ====
`timescale 1ns/100ps
`default_nettype none

module message_concat #(
    parameter int MAX_KEY_LENGTH = 16,   // bytes
    parameter int MAX_SUFFIX_LENGTH = 8, // bytes
    parameter int MAX_MSG_LENGTH = 32    // bytes
) (
    input wire clk,
    input wire reset,
    input wire secret_key_valid,
    input wire [4-1:0] secret_key_chars,
    input wire [8*MAX_KEY_LENGTH-1:0] secret_key_value, // left-aligned
    output logic suffix_ready,
    input wire suffix_valid,
    input wire [$clog2(1+MAX_SUFFIX_LENGTH)-1:0] suffix_digits,
    input wire [8*MAX_SUFFIX_LENGTH-1:0] suffix_number,
    input wire msg_ready,
    output logic msg_valid,
    output logic [$clog2(MAX_MSG_LENGTH)-1:0] msg_length, // delimiter not counted
    output logic [8*MAX_MSG_LENGTH-1:0] msg_data
);

localparam logic [7:0] DELIMITER = 8'h80;

typedef logic [8*MAX_MSG_LENGTH-1:0] msg_t;
typedef logic [$clog2(MAX_MSG_LENGTH)-1:0] msg_len_t;

msg_t key_part;
msg_t tail_part;
logic [8*MAX_SUFFIX_LENGTH-1:0] digits_part;
msg_len_t tail_shift;

always_comb begin
    key_part = '0;
    digits_part = '0;
    for (int i = 0; i < MAX_KEY_LENGTH; i++) begin
        if (i < secret_key_chars)
            key_part[8*(MAX_MSG_LENGTH-1-i)+:8] = secret_key_value[8*(MAX_KEY_LENGTH-1-i)+:8];
    end
    for (int j = 0; j < MAX_SUFFIX_LENGTH; j++) begin
        if (j < suffix_digits)
            digits_part[8*j+:8] = suffix_number[8*j+:8];
    end
    // msd lands right after the last key byte
    tail_shift = msg_len_t'(MAX_MSG_LENGTH) - msg_len_t'(secret_key_chars)
               - msg_len_t'(suffix_digits) - msg_len_t'(1);
    tail_part = msg_t'({digits_part, DELIMITER}) << (8*tail_shift);
end

// load when output register is free or being drained
assign suffix_ready = secret_key_valid && (msg_ready || !msg_valid);

always_ff @(posedge clk) begin
    if (reset) begin
        msg_valid <= 1'b0;
    end else if (suffix_ready) begin
        msg_valid <= suffix_valid;
    end
end

always_ff @(posedge clk) begin
    if (suffix_ready && suffix_valid) begin
        msg_length <= msg_len_t'(secret_key_chars) + msg_len_t'(suffix_digits);
        msg_data <= key_part | tail_part;
    end
end

endmodule

`default_nettype wire

// ==== hw/search_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module search_control #(
    parameter int ZERO_NIBBLES = 5
) (
    input wire clk,
    input wire reset,
    input wire start_req,
    output logic done_ack,
    output logic pipe_reset,
    output logic searching,
    input wire digest_valid,
    input wire md5_search_pkg::digest_t digest_in,
    output md5_search_pkg::answer_t answer,
    output md5_search_pkg::digest_t digest
);

import md5_search_pkg::*;

typedef enum logic [2:0] {
    st_idle,
    st_restart,
    st_search,
    st_done,
    st_release
} ctrl_state_t;

ctrl_state_t state;
answer_t count;
answer_t count_next;
logic hit;

// numbers come out strictly in order so the digest count is the number
assign count_next = count + 1'b1;
assign hit = (digest_in[$bits(digest_t)-1 -: 4*ZERO_NIBBLES] == '0);

assign pipe_reset = reset || (state == st_restart);
assign searching = (state == st_search);
assign done_ack = (state == st_release);

always_ff @(posedge clk) begin
    if (reset) begin
        state <= st_idle;
    end else begin
        case (state)
            st_idle: begin
                if (start_req)
                    state <= st_restart;
            end
            st_restart: state <= st_search;
            st_search: begin
                if (digest_valid && hit)
                    state <= st_done;
            end
            st_done: state <= st_release;
            st_release: begin
                if (!start_req) // host saw done_ack
                    state <= st_idle;
            end
            default: state <= st_idle;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (state == st_restart) begin
        count <= '0;
    end else if (state == st_search && digest_valid) begin
        count <= count_next;
        if (hit) begin
            answer <= count_next;
            digest <= digest_in;
        end
    end
end

endmodule

`default_nettype wire

// ==== testbench/md5_model.svh ====
`ifndef MD5_MODEL_SVH
`define MD5_MODEL_SVH

function automatic logic [31:0] byte_swap(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// single block only, len must stay below 56
function automatic logic [127:0] md5_of_bytes(input logic [7:0] msg [64], input int len);
    int rot [16] = '{7, 12, 17, 22, 5, 9, 14, 20, 4, 11, 16, 23, 6, 10, 15, 21};
    logic [31:0] init [4] = '{32'h67452301, 32'hefcdab89, 32'h98badcfe, 32'h10325476};
    logic [7:0] blk [64];
    logic [31:0] m [16];
    logic [31:0] a, b, c, d, f, k, t;
    logic [63:0] bits;
    real r;
    int g;
    int s;
    bits = 64'(len) * 8;
    for (int j = 0; j < 64; j++) begin
        if (j < len)
            blk[j] = msg[j];
        else if (j == len)
            blk[j] = 8'h80;
        else if (j >= 56)
            blk[j] = bits[8*(j-56)+:8]; // length field, little endian
        else
            blk[j] = 8'h00;
    end
    for (int w = 0; w < 16; w++)
        m[w] = {blk[4*w+3], blk[4*w+2], blk[4*w+1], blk[4*w]};
    a = init[0];
    b = init[1];
    c = init[2];
    d = init[3];
    for (int i = 0; i < 64; i++) begin
        case (i / 16)
            0: begin
                f = (b & c) | (~b & d);
                g = i;
            end
            1: begin
                f = (d & b) | (~d & c);
                g = (5 * i + 1) % 16;
            end
            2: begin
                f = b ^ c ^ d;
                g = (3 * i + 5) % 16;
            end
            default: begin
                f = c ^ (b | ~d);
                g = (7 * i) % 16;
            end
        endcase
        r = $sin(i + 1); // sine constant of the step
        if (r < 0.0)
            r = -r;
        k = 32'(longint'($floor(r * 4294967296.0)));
        s = rot[4 * (i / 16) + i % 4];
        t = a + f + k + m[g];
        a = d;
        d = c;
        c = b;
        b = b + ((t << s) | (t >> (32 - s)));
    end
    return {byte_swap(init[0] + a), byte_swap(init[1] + b),
            byte_swap(init[2] + c), byte_swap(init[3] + d)};
endfunction

function automatic int decimal_length(input int n);
    int len = 1;
    while (n >= 10) begin
        n = n / 10;
        len++;
    end
    return len;
endfunction

// key is left-aligned in 16 bytes, number follows as ascii decimal
function automatic logic [127:0] key_number_md5(input logic [127:0] key, input int key_len,
                                                input int n);
    logic [7:0] msg [64];
    int digits;
    int v;
    digits = decimal_length(n);
    v = n;
    for (int j = 0; j < 64; j++)
        msg[j] = 8'h00;
    for (int j = 0; j < key_len; j++)
        msg[j] = key[8*(15-j)+:8];
    for (int j = digits - 1; j >= 0; j--) begin
        msg[key_len + j] = 8'(v % 10) + "0";
        v = v / 10;
    end
    return md5_of_bytes(msg, key_len + digits);
endfunction

`endif

// ==== testbench/tb_md5_search.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_md5_search;

`include "md5_model.svh"

localparam int KEY_BYTES = 16;
localparam int ZERO_NIBBLES = 2;
localparam int SEARCHES = 3;
localparam int WATCHDOG_NS = SEARCHES * 600 * 70 * 8;

logic clk = 1'b0;
logic reset;
logic start_req;
logic [3:0] key_chars;
logic [8*KEY_BYTES-1:0] key_value;
logic done_ack;
logic [31:0] answer;
logic [127:0] digest;

int value_errors = 0;
int other_errors = 0;
int seed = 45;
logic start_seen;
logic done_q;
logic start_q;
logic [31:0] answer_q;
logic [127:0] digest_q;

md5_search_top #(
    .MAX_KEY_LENGTH(KEY_BYTES),
    .ZERO_NIBBLES(ZERO_NIBBLES)
) dut0 (
    .clk(clk),
    .reset(reset),
    .start_req(start_req),
    .key_chars(key_chars),
    .key_value(key_value),
    .done_ack(done_ack),
    .answer(answer),
    .digest(digest)
);

always #4 clk = ~clk;

task automatic compare_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    assert (actual === expected) else begin
        value_errors++;
        $display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
    end
endtask

task automatic report_error(input string what);
    other_errors++;
    $display("ERROR at %0t: %s", $time, what);
endtask

// handshake order and output stability
always @(posedge clk) begin
    if (reset) begin
        start_seen <= 1'b0;
        done_q <= 1'b0;
        start_q <= 1'b0;
    end else begin
        if (start_req)
            start_seen <= 1'b1;
        if (!start_seen)
            assert (!done_ack) else report_error("done_ack went high before any start_req");
        if (done_ack && !done_q)
            assert (start_req) else report_error("done_ack rose while start_req was low");
        if (!done_ack && done_q)
            assert (!start_q) else report_error("done_ack fell before start_req was dropped");
        if (done_ack && done_q) begin
            compare_value("answer", 128'(answer_q), 128'(answer));
            compare_value("digest", digest_q, digest);
        end
        done_q <= done_ack;
        start_q <= start_req;
        answer_q <= answer;
        digest_q <= digest;
    end
end

task automatic run_search(input logic [8*KEY_BYTES-1:0] key, input int len);
    logic [127:0] h;
    @(posedge clk);
    key_chars <= 4'(len);
    key_value <= key;
    start_req <= 1'b1;
    @(posedge clk);
    while (done_ack !== 1'b1)
        @(posedge clk);
    $display("key length %0d answer %0d digest %h", len, answer, digest);
    compare_value("digest", key_number_md5(key, len, int'(answer)), digest);
    compare_value("digest leading nibbles", '0, 128'(digest[127 -: 4*ZERO_NIBBLES]));
    assert (answer != 0) else report_error("answer is zero");
    if (answer > 100000) begin
        report_error("answer too large to check that it is the first hit");
    end else begin
        for (int i = 1; i < int'(answer); i++) begin
            h = key_number_md5(key, len, i);
            assert (h[127 -: 4*ZERO_NIBBLES] != '0) else
                report_error($sformatf("number %0d already hits, answer %0d is not the first",
                                       i, answer));
        end
    end
    repeat (3) @(posedge clk); // outputs must hold while start_req stays high
    start_req <= 1'b0;
    @(posedge clk);
    while (done_ack !== 1'b0)
        @(posedge clk);
endtask

initial begin
    logic [8*KEY_BYTES-1:0] key;
    int len;
    reset = 1'b1;
    start_req = 1'b0;
    key_chars = '0;
    key_value = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    repeat (20) @(posedge clk); // idle host
    for (int s = 0; s < SEARCHES; s++) begin
        len = (s == 0) ? 1 : 1 + int'({$random(seed)} % 15);
        // bytes past len are junk that the DUT has to mask
        for (int j = 0; j < KEY_BYTES; j++)
            key[8*(KEY_BYTES-1-j)+:8] = 8'("a" + {$random(seed)} % 26);
        run_search(key, len);
    end
    repeat (5) @(posedge clk);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0)
        $display("=== PASS ===");
    else
        $display("=== FAIL ===");
    $finish;
end

initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the searches did not finish", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
end

endmodule

`default_nettype wire
